// File: logic/timer.sv
//----------------------------------------------------------
// Dual channel timer top, bus on one side, two cores inside
//----------------------------------------------------------
`timescale 1ns/100ps
`include "timer_consts.svh"

module timer
  import timer_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset_n,

  // Chip select bus
  input  logic                         cs,
  input  logic                         we,
  input  logic [`TIMER_ADDR_WIDTH-1:0] address,
  input  timer_word_t                  write_data,
  output timer_word_t                  read_data,
  output logic                         ready
);

  // Config and status between the register block and cores
  timer_cfg_t  cfg0;
  timer_cfg_t  cfg1;
  timer_stat_t stat0;
  timer_stat_t stat1;

  //----------------------------------------------------------
  // Register block
  //----------------------------------------------------------
  timer_regs regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .ready      (ready),
    .cfg0       (cfg0),
    .cfg1       (cfg1),
    .stat0      (stat0),
    .stat1      (stat1)
  );

  //----------------------------------------------------------
  // Timer channels
  //----------------------------------------------------------
  timer_core core0 (
    .clk     (clk),
    .reset_n (reset_n),
    .cfg     (cfg0),
    .stat    (stat0)
  );

  timer_core core1 (
    .clk     (clk),
    .reset_n (reset_n),
    .cfg     (cfg1),
    .stat    (stat1)
  );

endmodule

// File: logic/timer_consts.svh
//----------------------------------------------------------
// Address map, bit positions and ID words for the dual timer
// Included by the package and by RTL that decodes addresses
//----------------------------------------------------------
`ifndef TIMER_CONSTS_SVH
`define TIMER_CONSTS_SVH

// Widths
`define TIMER_WIDTH          32
`define TIMER_ADDR_WIDTH     8
// Offset bits inside one channel block
`define TIMER_OFS_WIDTH      2

// Identification registers
`define TIMER_ADDR_NAME0     8'h00
`define TIMER_ADDR_NAME1     8'h01
`define TIMER_ADDR_VERSION   8'h02

// Channel blocks, four words each
`define TIMER_CH0_BASE       8'h08
`define TIMER_CH1_BASE       8'h10

// Word offsets within a channel block
`define TIMER_OFS_CTRL       2'd0
`define TIMER_OFS_STATUS     2'd1
`define TIMER_OFS_PRESCALER  2'd2
`define TIMER_OFS_TIMER      2'd3

// Control and status bits
`define TIMER_CTRL_START_BIT    0
`define TIMER_CTRL_STOP_BIT     1
`define TIMER_STATUS_READY_BIT  0

// ID words, "time" "r2ch" and version 4
`define TIMER_CORE_NAME0     32'h74696d65
`define TIMER_CORE_NAME1     32'h72326368
`define TIMER_CORE_VERSION   32'h00000004

`endif

// File: logic/timer_core.sv
//----------------------------------------------------------
// One countdown channel, prescaled, driven by a config struct
//----------------------------------------------------------
`timescale 1ns/100ps

module timer_core
  import timer_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  timer_cfg_t  cfg,
  output timer_stat_t stat
);

  //----------------------------------------------------------
  // State and counters
  //----------------------------------------------------------
  timer_state_e state;
  timer_state_e state_next;

  timer_word_t  curr_prescaler;
  timer_word_t  curr_prescaler_next;
  timer_word_t  curr_timer;
  timer_word_t  curr_timer_next;

  // Prescaler has run out, zero behaves like one
  logic         presc_tick;

  assign presc_tick = (curr_prescaler <= timer_word_t'(1));

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state          <= TIMER_IDLE;
      curr_prescaler <= '0;
      curr_timer     <= '0;
    end else begin
      state          <= state_next;
      curr_prescaler <= curr_prescaler_next;
      curr_timer     <= curr_timer_next;
    end
  end

  //----------------------------------------------------------
  // Next state and count logic
  //----------------------------------------------------------
  always_comb begin
    state_next          = state;
    curr_prescaler_next = curr_prescaler;
    curr_timer_next     = curr_timer;

    case (state)
      TIMER_IDLE: begin
        // Stop in the same pulse cancels the start
        if (cfg.start && !cfg.stop) begin
          curr_prescaler_next = cfg.prescaler;
          curr_timer_next     = cfg.timer;
          state_next          = TIMER_RUN;
        end
      end

      TIMER_RUN: begin
        if (cfg.stop) begin
          // Counts freeze where they are
          state_next = TIMER_IDLE;
        end else if (curr_timer == '0) begin
          // Started with zero ticks, one cycle in run
          state_next = TIMER_IDLE;
        end else if (presc_tick) begin
          curr_prescaler_next = cfg.prescaler;
          curr_timer_next     = curr_timer - timer_word_t'(1);
          // Last tick, leave run on the same edge
          if (curr_timer == timer_word_t'(1)) begin
            state_next = TIMER_IDLE;
          end
        end else begin
          curr_prescaler_next = curr_prescaler - timer_word_t'(1);
        end
      end

      default: begin
        state_next = TIMER_IDLE;
      end
    endcase
  end

  // Status back to the register block
  assign stat.ready          = (state == TIMER_IDLE);
  assign stat.curr_prescaler = curr_prescaler;
  assign stat.curr_timer     = curr_timer;

endmodule

// File: logic/timer_pkg.sv
//----------------------------------------------------------
// Types shared by the register block and the timer cores
//----------------------------------------------------------
`include "timer_consts.svh"

package timer_pkg;

  // Bus and counter word
  typedef logic [`TIMER_WIDTH-1:0] timer_word_t;

  //----------------------------------------------------------
  // Register block to core
  //----------------------------------------------------------
  typedef struct packed {
    timer_word_t prescaler;  // Cycles per timer tick
    timer_word_t timer;      // Ticks to count
    logic        start;      // One cycle pulse
    logic        stop;       // One cycle pulse, wins over start
  } timer_cfg_t;

  //----------------------------------------------------------
  // Core to register block
  //----------------------------------------------------------
  typedef struct packed {
    logic        ready;           // High while idle
    timer_word_t curr_prescaler;
    timer_word_t curr_timer;
  } timer_stat_t;

  // Core FSM
  typedef enum logic {
    TIMER_IDLE = 1'b0,
    TIMER_RUN  = 1'b1
  } timer_state_e;

endpackage

// File: logic/timer_regs.sv
//----------------------------------------------------------
// Bus decode and registers for two timer channels
// Holds per channel config, makes start/stop pulses, muxes reads
//----------------------------------------------------------
`timescale 1ns/100ps
`include "timer_consts.svh"

module timer_regs
  import timer_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset_n,

  input  logic                         cs,
  input  logic                         we,
  input  logic [`TIMER_ADDR_WIDTH-1:0] address,
  input  timer_word_t                  write_data,
  output timer_word_t                  read_data,
  output logic                         ready,

  output timer_cfg_t                   cfg0,
  output timer_cfg_t                   cfg1,
  input  timer_stat_t                  stat0,
  input  timer_stat_t                  stat1
);

  localparam int NUM_CH = 2;

  localparam logic [`TIMER_ADDR_WIDTH-1:0] CH0_BASE = `TIMER_CH0_BASE;
  localparam logic [`TIMER_ADDR_WIDTH-1:0] CH1_BASE = `TIMER_CH1_BASE;

  //----------------------------------------------------------
  // Address split
  //----------------------------------------------------------
  logic [`TIMER_ADDR_WIDTH-1:`TIMER_OFS_WIDTH] page;
  logic [`TIMER_OFS_WIDTH-1:0]                 offset;
  logic [NUM_CH-1:0]                           ch_hit;
  logic                                        wr_en;

  assign page   = address[`TIMER_ADDR_WIDTH-1:`TIMER_OFS_WIDTH];
  assign offset = address[`TIMER_OFS_WIDTH-1:0];
  assign wr_en  = cs && we;

  // Channel select from the upper address bits
  assign ch_hit[0] = (page == CH0_BASE[`TIMER_ADDR_WIDTH-1:`TIMER_OFS_WIDTH]);
  assign ch_hit[1] = (page == CH1_BASE[`TIMER_ADDR_WIDTH-1:`TIMER_OFS_WIDTH]);

  // No wait states
  assign ready = cs;

  //----------------------------------------------------------
  // Per channel storage
  //----------------------------------------------------------
  timer_word_t       prescaler_q [NUM_CH];
  timer_word_t       timer_q     [NUM_CH];
  logic [NUM_CH-1:0] start_q;
  logic [NUM_CH-1:0] stop_q;
  timer_stat_t       stat_ch     [NUM_CH];

  assign stat_ch[0] = stat0;
  assign stat_ch[1] = stat1;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      start_q <= '0;
      stop_q  <= '0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        prescaler_q[ch] <= '0;
        timer_q[ch]     <= '0;
      end
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        // Pulses last one cycle, cleared on any other cycle
        start_q[ch] <= wr_en && ch_hit[ch] && (offset == `TIMER_OFS_CTRL) &&
                       write_data[`TIMER_CTRL_START_BIT];
        stop_q[ch]  <= wr_en && ch_hit[ch] && (offset == `TIMER_OFS_CTRL) &&
                       write_data[`TIMER_CTRL_STOP_BIT];

        // Config only changes while the channel is idle
        if (wr_en && ch_hit[ch] && stat_ch[ch].ready) begin
          if (offset == `TIMER_OFS_PRESCALER) begin
            prescaler_q[ch] <= write_data;
          end
          if (offset == `TIMER_OFS_TIMER) begin
            timer_q[ch] <= write_data;
          end
        end
      end
    end
  end

  // Config out to the cores
  assign cfg0.prescaler = prescaler_q[0];
  assign cfg0.timer     = timer_q[0];
  assign cfg0.start     = start_q[0];
  assign cfg0.stop      = stop_q[0];

  assign cfg1.prescaler = prescaler_q[1];
  assign cfg1.timer     = timer_q[1];
  assign cfg1.start     = start_q[1];
  assign cfg1.stop      = stop_q[1];

  //----------------------------------------------------------
  // Read mux
  //----------------------------------------------------------
  always_comb begin
    read_data = '0;

    // Identification words
    if (address == `TIMER_ADDR_NAME0) begin
      read_data = `TIMER_CORE_NAME0;
    end else if (address == `TIMER_ADDR_NAME1) begin
      read_data = `TIMER_CORE_NAME1;
    end else if (address == `TIMER_ADDR_VERSION) begin
      read_data = `TIMER_CORE_VERSION;
    end

    // Channel blocks, control reads back as zero
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (ch_hit[ch]) begin
        case (offset)
          `TIMER_OFS_STATUS: begin
            read_data[`TIMER_STATUS_READY_BIT] = stat_ch[ch].ready;
          end
          `TIMER_OFS_PRESCALER: begin
            read_data = stat_ch[ch].curr_prescaler;
          end
          `TIMER_OFS_TIMER: begin
            read_data = stat_ch[ch].curr_timer;
          end
          default: begin
            read_data = '0;
          end
        endcase
      end
    end
  end

endmodule

// File: sim.f
+incdir+logic
logic/timer_pkg.sv
logic/timer_core.sv
logic/timer_regs.sv
logic/timer.sv
verif/tb_clock.sv
verif/timer_tb.sv

// File: verif/tb_clock.sv
//----------------------------------------------------------
// Testbench clock, 8 ns period, reset low for two cycles
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Release reset on a falling edge after two rising edges
  initial begin
    reset_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  end

endmodule

// File: verif/timer_tb.sv
//----------------------------------------------------------
// Dual timer testbench with random values from a fixed seed
// Bus driven on falling edges and checked against a channel model
//----------------------------------------------------------
`timescale 1ns/100ps
`include "timer_consts.svh"

module timer_tb
  import timer_pkg::*;
;

  logic                         clk;
  logic                         reset_n;
  logic                         cs;
  logic                         we;
  logic [`TIMER_ADDR_WIDTH-1:0] address;
  timer_word_t                  write_data;
  timer_word_t                  read_data;
  logic                         ready;

  tb_clock clock_gen (.clk(clk), .reset_n(reset_n));

  timer uut (
    .clk(clk), .reset_n(reset_n), .cs(cs), .we(we), .address(address),
    .write_data(write_data), .read_data(read_data), .ready(ready)
  );

  //----------------------------------------------------------
  // Channel model
  //----------------------------------------------------------
  int          cyc;
  timer_word_t stored_p [2];
  timer_word_t stored_t [2];
  timer_word_t cur_p    [2];
  timer_word_t cur_t    [2];
  bit          active   [2];
  bit          stopped  [2];
  int          start_cyc [2];
  int          stop_cyc  [2];
  int          run_len   [2];

  // Expected STATUS ready in the current bus cycle
  function automatic bit expect_ready(int ch);
    int k;
    if (!active[ch]) return 1'b1;
    if (stopped[ch]) return (cyc - stop_cyc[ch]) >= 2;
    k = cyc - start_cyc[ch];
    // Pulse needs one edge and the core changes state on the next
    return (k <= 1) || (k >= run_len[ch] + 2);
  endfunction

  function automatic logic [`TIMER_ADDR_WIDTH-1:0] reg_addr(int ch, int ofs);
    logic [`TIMER_ADDR_WIDTH-1:0] base;
    base = (ch == 0) ? `TIMER_CH0_BASE : `TIMER_CH1_BASE;
    return base + ofs;
  endfunction

  //----------------------------------------------------------
  // Compare tasks
  //----------------------------------------------------------
  task automatic check_word(string name, timer_word_t exp, timer_word_t act);
    if (exp !== act) begin
      $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "word compare failed");
    end
  endtask

  task automatic check_ready(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("Mismatch at %0t ns: %s expected %b actual %b", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "bit compare failed");
    end
  endtask

  //----------------------------------------------------------
  // Bus tasks of one bus cycle each
  //----------------------------------------------------------
  task automatic drive_bus(logic c, logic w, logic [`TIMER_ADDR_WIDTH-1:0] a,
                           timer_word_t d);
    @(negedge clk);
    cs         = c;
    we         = w;
    address    = a;
    write_data = d;
    cyc++;
    #1;
    check_ready("ready", c, ready);
  endtask

  task automatic bus_idle();
    drive_bus(1'b0, 1'b0, '0, '0);
  endtask

  task automatic bus_read(logic [`TIMER_ADDR_WIDTH-1:0] a, output timer_word_t d);
    drive_bus(1'b1, 1'b0, a, '0);
    d = read_data;
  endtask

  // Write one channel register and update the model
  task automatic bus_write(int ch, int ofs, timer_word_t d);
    int  m;
    int  p;
    bit  idle;
    drive_bus(1'b1, 1'b1, reg_addr(ch, ofs), d);
    idle = expect_ready(ch);
    p    = (stored_p[ch] == 0) ? 1 : int'(stored_p[ch]);
    if (ofs == `TIMER_OFS_PRESCALER && idle) stored_p[ch] = d;
    if (ofs == `TIMER_OFS_TIMER && idle) stored_t[ch] = d;
    if (ofs == `TIMER_OFS_CTRL) begin
      if (d[`TIMER_CTRL_STOP_BIT] && !idle && !stopped[ch]) begin
        // Run edges seen before the stop edge
        m            = cyc - start_cyc[ch] - 1;
        stopped[ch]  = 1'b1;
        stop_cyc[ch] = cyc;
        cur_t[ch]    = stored_t[ch] - timer_word_t'(m / p);
        cur_p[ch]    = (m % p == 0) ? stored_p[ch] : stored_p[ch] - timer_word_t'(m % p);
      end else if (d[`TIMER_CTRL_START_BIT] && !d[`TIMER_CTRL_STOP_BIT] && idle) begin
        active[ch]    = 1'b1;
        stopped[ch]   = 1'b0;
        start_cyc[ch] = cyc;
        run_len[ch]   = (stored_t[ch] * p == 0) ? 1 : int'(stored_t[ch]) * p;
        // Values left at natural completion
        cur_p[ch]     = stored_p[ch];
        cur_t[ch]     = '0;
      end
    end
  endtask

  task automatic read_status(int ch, output logic rdy);
    timer_word_t d;
    bus_read(reg_addr(ch, `TIMER_OFS_STATUS), d);
    check_ready($sformatf("ch%0d status", ch), expect_ready(ch), d[0]);
    check_word($sformatf("ch%0d status word", ch), timer_word_t'(expect_ready(ch)), d);
    rdy = d[0];
  endtask

  // Value reads are only legal while the model says idle
  task automatic check_values(int ch);
    timer_word_t d;
    bus_read(reg_addr(ch, `TIMER_OFS_PRESCALER), d);
    check_word($sformatf("ch%0d prescaler", ch), cur_p[ch], d);
    bus_read(reg_addr(ch, `TIMER_OFS_TIMER), d);
    check_word($sformatf("ch%0d timer", ch), cur_t[ch], d);
  endtask

  task automatic load_channel(int ch, timer_word_t p, timer_word_t t);
    bus_write(ch, `TIMER_OFS_PRESCALER, p);
    bus_write(ch, `TIMER_OFS_TIMER, t);
  endtask

  //----------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------
  initial begin
    timer_word_t d;
    timer_word_t t_a;
    int          n;
    logic        rdy;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    cyc = 0;
    for (int ch = 0; ch < 2; ch++) begin
      stored_p[ch] = '0;
      stored_t[ch] = '0;
      cur_p[ch]    = '0;
      cur_t[ch]    = '0;
      active[ch]   = 1'b0;
      stopped[ch]  = 1'b0;
    end
    void'($urandom(32'h4fd0));
    n = 0;
    while (reset_n !== 1'b1) begin
      if (n > 20) begin
        $display("Reset never released");
        $display("TEST FAIL");
        $fatal(1, "timeout");
      end
      @(posedge clk);
      n++;
    end

    // Identification words
    bus_read(`TIMER_ADDR_NAME0, d);
    check_word("name0", `TIMER_CORE_NAME0, d);
    bus_read(`TIMER_ADDR_NAME1, d);
    check_word("name1", `TIMER_CORE_NAME1, d);
    bus_read(`TIMER_ADDR_VERSION, d);
    check_word("version", `TIMER_CORE_VERSION, d);
    bus_idle();

    // Config writes to idle channels leave the current counts untouched
    for (int ch = 0; ch < 2; ch++) begin
      load_channel(ch, $urandom_range(12, 0), $urandom_range(20, 0));
      check_values(ch);
      read_status(ch, rdy);
    end

    // Timed runs with dropped writes during the run
    for (int i = 0; i < 6; i++) begin
      int ch;
      ch = i % 2;
      load_channel(ch, $urandom_range(12, 0), $urandom_range(20, 0));
      bus_write(ch, `TIMER_OFS_CTRL, 32'h1);
      bus_idle();
      rdy = 1'b0;
      n   = 1;
      while (!rdy) begin
        if (n > 400) begin
          $display("Channel %0d never finished its timed run", ch);
          $display("TEST FAIL");
          $fatal(1, "timeout");
        end
        // Writes while busy must be dropped
        if (!expect_ready(ch) && n < 4) begin
          bus_write(ch, $urandom_range(3, 2), $urandom_range(20, 0));
        end else begin
          read_status(ch, rdy);
        end
        n++;
      end
      check_values(ch);
    end

    // Stop partway through a run
    load_channel(0, $urandom_range(12, 2), $urandom_range(20, 5));
    bus_write(0, `TIMER_OFS_CTRL, 32'h1);
    n = $urandom_range(7, 3);
    repeat (n - 1) bus_idle();
    bus_write(0, `TIMER_OFS_CTRL, 32'h2);
    bus_idle();
    read_status(0, rdy);
    bus_read(reg_addr(0, `TIMER_OFS_TIMER), t_a);
    check_word("ch0 timer after stop", cur_t[0], t_a);
    repeat (3) bus_idle();
    check_values(0);

    // Both channels together with their own lengths
    load_channel(0, $urandom_range(12, 1), $urandom_range(20, 1));
    load_channel(1, $urandom_range(12, 1), $urandom_range(20, 1));
    if (stored_t[1] == stored_t[0]) bus_write(1, `TIMER_OFS_TIMER, stored_t[0] % 20 + 1);
    bus_write(0, `TIMER_OFS_CTRL, 32'h1);
    bus_write(1, `TIMER_OFS_CTRL, 32'h1);
    n = 0;
    while (!expect_ready(0) || !expect_ready(1) || n < 2) begin
      if (n > 600) begin
        $display("Channel %0d never finished the joint run", expect_ready(0) ? 1 : 0);
        $display("TEST FAIL");
        $fatal(1, "timeout");
      end
      read_status(n % 2, rdy);
      if (n % 5 == 0) bus_write((n / 5) % 2, `TIMER_OFS_PRESCALER, $urandom_range(12, 0));
      n++;
    end
    read_status(0, rdy);
    read_status(1, rdy);
    check_values(0);
    check_values(1);
    bus_idle();

    $display("TEST PASS");
    $finish;
  end

endmodule
